// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    // first fetch after reset.
    localparam logic [31:0] reset_pc = 32'h0000_0004;

    // primary opcodes.
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes.
    localparam logic [5:0] fn_sll  = 6'h00; // all-zero word is nop.
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;

    // regimm rt field selects the branch.
    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

    localparam logic [4:0] reg_v0 = 5'd2;

    // controller states.
    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_fetch  = 3'd1;
    localparam logic [2:0] st_decode = 3'd2;
    localparam logic [2:0] st_exec   = 3'd3;
    localparam logic [2:0] st_mem    = 3'd4;
    localparam logic [2:0] st_wb     = 3'd5;
    localparam logic [2:0] st_halt   = 3'd6;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // same word, two field layouts.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_pass, // forwards alu_a, used for the jr target.
        alu_none
    } alu_op_t;

endpackage

// ==== src/avalon_if.sv ====
`timescale 1ns/1ns

interface avalon_if;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic        waitrequest;
    logic [31:0] readdata; // captured copy, valid the cycle after accept.

    modport ctrl (
        output address, read, write, writedata, byteenable,
        input  waitrequest, readdata
    );

    modport bus (
        input  address, read, write, writedata, byteenable,
        output waitrequest, readdata
    );

endinterface

// ==== src/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin // r0 stays zero.
            regs[wr_addr] <= wr_data;
        end
    end

    // asynchronous reads.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    assign v0 = regs[reg_v0]; // for the top-level register_v0 port.

endmodule

// ==== src/alu_branch.sv ====
`timescale 1ns/1ns

module alu_branch import cpu_pkg::*; (
    input  logic [31:0] alu_a,
    input  logic [31:0] alu_b,
    input  logic [31:0] imm,         // already sign-extended.
    input  alu_op_t     alu_op,
    input  logic [4:0]  branch_kind, // regimm rt field.
    input  logic        branch_en,
    input  logic [31:0] pc_next,     // address of the delay slot.
    output logic [31:0] result,
    output logic        taken,
    output logic [31:0] target
);

    logic sign_a;

    assign sign_a = alu_a[31];

    always_comb begin
        case (alu_op)
            alu_add:  result = alu_a + alu_b; // wraps, no overflow trap.
            alu_pass: result = alu_a;
            default:  result = '0;
        endcase
    end

    // branch condition on the sign of rs.
    always_comb begin
        taken = 1'b0;
        if (branch_en) begin
            case (branch_kind)
                rt_bgez: taken = !sign_a;
                rt_bltz: taken = sign_a;
                default: taken = 1'b0;
            endcase
        end
    end

    // offset counts words from the delay slot.
    assign target = pc_next + {imm[29:0], 2'b00};

endmodule

// ==== src/bus_unit.sv ====
`timescale 1ns/1ns

module bus_unit (
    input  logic        clk,
    input  logic        arst_n,
    avalon_if.bus       m,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  logic        waitrequest,
    input  logic [31:0] readdata
);

    logic [31:0] rd_q;
    logic        rd_accept;

    // request goes straight out, no added latency.
    assign address    = m.address;
    assign read       = m.read;
    assign write      = m.write;
    assign writedata  = m.writedata;
    assign byteenable = m.byteenable;

    assign m.waitrequest = waitrequest;

    // read is accepted on the edge where waitrequest is low.
    assign rd_accept = m.read && !waitrequest;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_q <= '0;
        end else if (rd_accept) begin
            rd_q <= readdata;
        end
    end

    // controller picks this up in the state after the transfer.
    assign m.readdata = rd_q;

endmodule

// ==== src/cpu_ctrl.sv ====
`timescale 1ns/1ns

module cpu_ctrl import cpu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    avalon_if.ctrl      m,
    output logic [4:0]  rs_addr,
    output logic [4:0]  rt_addr,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [31:0] wr_data,
    output logic [31:0] alu_a,
    output logic [31:0] alu_b,
    output logic [31:0] imm,
    output alu_op_t     alu_op,
    output logic [4:0]  branch_kind,
    output logic        branch_en,
    output logic [31:0] pc_next,
    input  logic [31:0] result,
    input  logic        taken,
    input  logic [31:0] target,
    output logic        active
);

    logic [2:0]  state;
    logic [31:0] pc;          // address of the current instruction.
    instr_t      ir;
    logic [31:0] addr_q;      // lw/sw address from exec.
    logic        slot;        // current instruction sits in a delay slot.
    logic [31:0] pend_target;

    logic wb_rd, wb_rt, b_from_rt;
    logic is_jr, is_lw, is_sw;
    logic mem_op, retire, redirect;

    always_comb begin
        alu_op    = alu_none;
        wb_rd     = 1'b0;
        wb_rt     = 1'b0;
        b_from_rt = 1'b0;
        is_jr     = 1'b0;
        is_lw     = 1'b0;
        is_sw     = 1'b0;
        branch_en = 1'b0;
        case (ir.r.op)
            op_special: begin
                case (ir.r.funct)
                    fn_addu: begin
                        alu_op    = alu_add;
                        wb_rd     = 1'b1;
                        b_from_rt = 1'b1;
                    end
                    fn_jr: begin
                        alu_op = alu_pass;
                        is_jr  = 1'b1;
                    end
                    fn_sll:  alu_op = alu_none; // only the nop form is supported.
                    default: alu_op = alu_none;
                endcase
            end
            op_regimm: branch_en = 1'b1;
            op_addiu: begin
                alu_op = alu_add;
                wb_rt  = 1'b1;
            end
            op_lw: begin
                alu_op = alu_add;
                is_lw  = 1'b1;
            end
            op_sw: begin
                alu_op = alu_add;
                is_sw  = 1'b1;
            end
            default: alu_op = alu_none;
        endcase
    end

    assign rs_addr     = ir.r.rs;
    assign rt_addr     = ir.r.rt;
    assign imm         = {{16{ir.i.imm[15]}}, ir.i.imm};
    assign alu_a       = rs_data;
    assign alu_b       = b_from_rt ? rt_data : imm;
    assign branch_kind = ir.i.rt;
    assign pc_next     = pc + 32'd4;

    assign mem_op   = is_lw || is_sw;
    assign retire   = (state == st_exec && !mem_op) || state == st_wb;
    assign redirect = is_jr || taken;

    // alu results land in exec, load data in wb.
    assign wr_en   = (state == st_exec && (wb_rd || wb_rt)) || (state == st_wb && is_lw);
    assign wr_addr = wb_rd ? ir.r.rd : ir.r.rt;
    assign wr_data = (state == st_wb) ? m.readdata : result;

    assign m.address    = (state == st_mem) ? addr_q : pc;
    assign m.read       = state == st_fetch || (state == st_mem && is_lw);
    assign m.write      = state == st_mem && is_sw;
    assign m.writedata  = rt_data;
    assign m.byteenable = 4'hf;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            pc          <= reset_pc;
            active      <= 1'b0;
            slot        <= 1'b0;
            pend_target <= '0;
        end else begin
            case (state)
                st_idle: begin
                    active <= 1'b1;
                    state  <= st_fetch;
                end
                st_fetch: if (!m.waitrequest) state <= st_decode;
                st_decode: state <= st_exec;
                st_exec: if (mem_op) state <= st_mem;
                st_mem: if (!m.waitrequest) state <= st_wb;
                st_halt: active <= 1'b0; // drops one cycle after the slot retires.
                default: state <= st_halt;
            endcase

            if (retire) begin
                if (slot) begin
                    pc    <= pend_target;
                    slot  <= 1'b0;
                    state <= (pend_target == 32'd0) ? st_halt : st_fetch;
                end else begin
                    pc    <= pc_next;
                    state <= st_fetch;
                end
                if (redirect) begin // delay slot runs first.
                    slot        <= 1'b1;
                    pend_target <= is_jr ? result : target;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            ir <= m.readdata;
        end
        if (state == st_exec) begin
            addr_q <= result;
        end
    end

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  logic        waitrequest,
    input  logic [31:0] readdata
);

    avalon_if av ();

    logic [4:0]  rs_addr, rt_addr, wr_addr, branch_kind;
    logic [31:0] rs_data, rt_data, wr_data;
    logic [31:0] alu_a, alu_b, imm, pc_next, result, target;
    logic        wr_en, branch_en, taken;
    alu_op_t     alu_op;

    cpu_ctrl ctrl_i (
        .clk(clk), .arst_n(arst_n), .m(av.ctrl),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .alu_a(alu_a), .alu_b(alu_b), .imm(imm), .alu_op(alu_op),
        .branch_kind(branch_kind), .branch_en(branch_en), .pc_next(pc_next),
        .result(result), .taken(taken), .target(target), .active(active)
    );

    reg_file rf_i (
        .clk(clk), .arst_n(arst_n),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .v0(register_v0)
    );

    alu_branch alu_i (
        .alu_a(alu_a), .alu_b(alu_b), .imm(imm), .alu_op(alu_op),
        .branch_kind(branch_kind), .branch_en(branch_en), .pc_next(pc_next),
        .result(result), .taken(taken), .target(target)
    );

    bus_unit bus_i (
        .clk(clk), .arst_n(arst_n), .m(av.bus),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata)
    );

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/1ns

module mem_model (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata
);

    logic [31:0] mem [256];   // word addressed, byte address bits 9:2.
    int unsigned stall;
    int unsigned wait_left;
    int          xfers;       // accepted transfers since reset.

    // zero-wait data once waitrequest is low.
    assign readdata = mem[address[9:2]];

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            waitrequest <= 1'b0;
            wait_left   <= 0;
            xfers       <= 0;
        end else if (read || write) begin
            if (!waitrequest) begin
                if (write) begin
                    mem[address[9:2]] <= writedata;
                end
                xfers <= xfers + 1;
                // stall length for the next transfer.
                stall = $urandom_range(3, 0);
                waitrequest <= (stall != 0);
                wait_left   <= (stall != 0) ? stall - 1 : 0;
            end else if (wait_left == 0) begin
                waitrequest <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    task automatic preload(input int idx, input logic [31:0] data);
        mem[idx] = data;
    endtask

endmodule

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

    localparam int n_programs  = 5;
    localparam int max_instr   = 48;
    localparam int halt_window = 20;

    logic        clk, arst_n, active, read, write, waitrequest;
    logic [31:0] register_v0, address, writedata, readdata;
    logic [3:0]  byteenable;

    logic [31:0] image [256];
    logic [31:0] ref_mem [256];
    logic [31:0] exp_v0;
    int          exp_transfers;
    int          wp;
    int          errors = 0;
    int          checks = 0;
    int          compared = 0;
    int unsigned seed;

    cpu_top cpu_top_i (
        .clk(clk), .arst_n(arst_n), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata)
    );

    mem_model mem_i (
        .clk(clk), .arst_n(arst_n), .address(address), .read(read), .write(write),
        .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] i_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] r_word(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] fn);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    // fill pattern everywhere before the program goes in at reset_pc.
    task automatic new_image();
        for (int i = 0; i < 256; i++) begin
            image[i] = {8'hd0, i[7:0], ~i[7:0], 8'h0b};
        end
        wp = reset_pc[9:2];
    endtask

    task automatic emit(logic [31:0] word);
        image[wp] = word;
        wp++;
    endtask

    // instruction set model stepping one instruction at a time.
    function automatic void ref_run(output logic [31:0] v0, output int transfers);
        logic [31:0] regs [32];
        logic [31:0] pc, word, simm, addr, tgt, pend;
        logic [4:0]  rs, rt, rd;
        logic        in_slot, redirect;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = image[i];
        end
        pc        = reset_pc;
        pend      = '0;
        in_slot   = 1'b0;
        transfers = 0;
        for (int n = 0; n < 1000; n++) begin
            word = ref_mem[pc[9:2]];
            rs   = word[25:21];
            rt   = word[20:16];
            rd   = word[15:11];
            simm = {{16{word[15]}}, word[15:0]};
            addr = regs[rs] + simm;
            tgt  = pc + 32'd4 + (simm << 2); // relative to the delay slot.
            redirect = 1'b0;
            transfers++;
            case (word[31:26])
                op_special: begin
                    if (word[5:0] == fn_addu) begin
                        regs[rd] = regs[rs] + regs[rt];
                    end else if (word[5:0] == fn_jr) begin
                        redirect = 1'b1;
                        tgt      = regs[rs];
                    end
                end
                op_regimm: redirect = (rt == rt_bgez) ? !regs[rs][31]
                                                      : (rt == rt_bltz) && regs[rs][31];
                op_addiu:  regs[rt] = regs[rs] + simm;
                op_lw: begin
                    regs[rt] = ref_mem[addr[9:2]];
                    transfers++;
                end
                op_sw: begin
                    ref_mem[addr[9:2]] = regs[rt];
                    transfers++;
                end
                default: ;
            endcase
            regs[0] = '0;
            if (in_slot) begin
                in_slot = 1'b0;
                if (pend == 32'd0) break; // halt after the slot.
                pc = pend;
            end else begin
                pc = pc + 32'd4;
            end
            if (redirect) begin
                in_slot = 1'b1;
                pend    = tgt;
            end
        end
        v0 = regs[reg_v0];
    endfunction

    task automatic compare_results();
        checks++;
        assert (register_v0 === exp_v0) else begin
            errors++;
            $display("[FAIL] register_v0 expected %h got %h", exp_v0, register_v0);
        end
        checks++;
        assert (mem_i.xfers == exp_transfers) else begin
            errors++;
            $display("[FAIL] mem_i.xfers expected %h got %h", exp_transfers, mem_i.xfers);
        end
        for (int i = 0; i < 256; i++) begin
            assert (mem_i.mem[i] === ref_mem[i]) else begin
                errors++;
                $display("[FAIL] mem[%h] expected %h got %h", i, ref_mem[i], mem_i.mem[i]);
            end
        end
    endtask

    task automatic check_idle_bus();
        checks++;
        assert (!read && !write && !active) else begin
            errors++;
            $display("[FAIL] read/write/active expected 0/0/0 got %h/%h/%h",
                     read, write, active);
        end
    endtask

    // reset, load, run to halt, then watch the bus stay quiet.
    task automatic run_program(input string name);
        int cycles;
        int n_before;
        @(posedge clk);
        arst_n <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem_i.preload(i, image[i]);
        end
        ref_run(exp_v0, exp_transfers);
        repeat (10) begin
            @(negedge clk);
            check_idle_bus();
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_idle_bus();
        cycles = 0;
        while (!read && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        assert (read && address == reset_pc) else begin
            errors++;
            $display("[FAIL] address expected %h got %h", reset_pc, address);
        end
        n_before = compared;
        cycles   = 0;
        while (compared == n_before && cycles < max_instr * 60) begin
            @(negedge clk);
            cycles++;
        end
        if (compared == n_before) begin
            errors++;
            $display("program %s never dropped active", name);
        end else begin
            repeat (halt_window) begin
                @(negedge clk);
                checks++;
                assert (!read && !write) else begin
                    errors++;
                    $display("program %s issued a bus transfer after halting", name);
                end
            end
        end
    endtask

    // compare once the CPU drops active outside reset.
    initial begin
        forever begin
            @(negedge active);
            @(negedge clk);
            if (arst_n) begin
                compare_results();
                compared++;
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n && (read || write)) begin
            checks++;
            assert (byteenable == 4'hf) else begin
                errors++;
                $display("[FAIL] byteenable expected %h got %h", 4'hf, byteenable);
            end
        end
    end

    initial begin
        #(n_programs * max_instr * 60 * 8); // 60 cycles of 8 ns per instruction.
        errors++;
        $display("watchdog expired before all programs finished");
        $display("summary: %0d checks, %0d errors", checks, errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        seed = $urandom(32'hbb62);
        arst_n <= 1'b0;

        // taken bgez skips one word while the slot still runs.
        new_image();
        emit(i_word(op_addiu, 5'd0, reg_v0, 16'h0050));
        emit(i_word(op_regimm, reg_v0, rt_bgez, 16'd2));
        emit(i_word(op_addiu, reg_v0, reg_v0, 16'h0050));
        emit(i_word(op_addiu, reg_v0, reg_v0, 16'h0001));
        emit(r_word(5'd0, 5'd0, 5'd0, fn_jr));
        emit(32'd0);
        run_program("bgez");
        checks++;
        assert (register_v0 == 32'h0000_00a0) else begin
            errors++;
            $display("[FAIL] register_v0 expected %h got %h", 32'h0000_00a0, register_v0);
        end

        new_image();
        emit(i_word(op_addiu, 5'd0, 5'd3, 16'hffff));
        emit(i_word(op_addiu, 5'd3, reg_v0, 16'h0002)); // wraps around to 1.
        emit(i_word(op_addiu, 5'd3, 5'd0, 16'h0005));
        for (int k = 0; k < 20; k++) begin
            if ($urandom_range(1, 0) == 1)
                emit(r_word(5'($urandom_range(5, 0)), 5'($urandom_range(5, 0)),
                            5'($urandom_range(5, 0)), fn_addu));
            else
                emit(i_word(op_addiu, 5'($urandom_range(5, 0)), 5'($urandom_range(5, 0)),
                            16'($urandom)));
        end
        emit(r_word(5'd0, 5'd0, 5'd0, fn_jr));
        emit(32'd0);
        run_program("arith");

        new_image();
        for (int k = 0; k < 6; k++) begin
            emit(i_word(op_addiu, 5'd0, 5'd3, 16'($urandom)));
            emit(i_word(op_regimm, 5'd3, ($urandom_range(1, 0) == 1) ? rt_bgez : rt_bltz,
                        16'd2));
            emit(i_word(op_addiu, reg_v0, reg_v0, 16'($urandom_range(255, 1))));
            emit(i_word(op_addiu, reg_v0, reg_v0, 16'h1000)); // skipped when taken.
        end
        emit(r_word(5'd0, 5'd0, 5'd0, fn_jr));
        emit(i_word(op_addiu, reg_v0, reg_v0, 16'h0001));
        run_program("branch");

        new_image();
        emit(i_word(op_addiu, 5'd0, 5'd4, 16'h0200));
        for (int k = 0; k < 6; k++) begin
            emit(i_word(op_addiu, 5'd0, 5'd5, 16'($urandom)));
            emit(i_word(op_sw, 5'd4, 5'd5, 16'($urandom_range(15, 0) * 4)));
        end
        for (int k = 0; k < 6; k++) begin
            emit(i_word(op_lw, 5'd4, 5'd6, 16'($urandom_range(19, 0) * 4)));
            emit(r_word(reg_v0, 5'd6, reg_v0, fn_addu));
        end
        emit(r_word(5'd0, 5'd0, 5'd0, fn_jr));
        emit(32'd0);
        run_program("memory");

        // jr to a real target first and then to zero.
        new_image();
        emit(i_word(op_addiu, 5'd0, reg_v0, 16'h0007));
        emit(i_word(op_addiu, 5'd0, 5'd3, 16'h0020));
        emit(r_word(5'd3, 5'd0, 5'd0, fn_jr));
        emit(i_word(op_addiu, reg_v0, reg_v0, 16'h0010));
        emit(i_word(op_addiu, reg_v0, reg_v0, 16'h0100));
        wp = 8;
        emit(r_word(5'd0, 5'd0, 5'd0, fn_jr));
        emit(i_word(op_addiu, reg_v0, reg_v0, 16'h1000));
        emit(i_word(op_addiu, reg_v0, reg_v0, 16'h0007));
        run_program("halt");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
src/cpu_pkg.sv
src/avalon_if.sv
src/reg_file.sv
src/alu_branch.sv
src/bus_unit.sv
src/cpu_ctrl.sv
src/cpu_top.sv
verif/mem_model.sv
verif/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: mips_avalon_cpu

sources:
  - files:
      - src/cpu_pkg.sv
      - src/avalon_if.sv
      - src/reg_file.sv
      - src/alu_branch.sv
      - src/bus_unit.sv
      - src/cpu_ctrl.sv
      - src/cpu_top.sv
  - target: test
    files:
      - verif/mem_model.sv
      - verif/cpu_tb.sv
